// File: hw/rst_seq_pkg.sv
`default_nettype none

package rst_seq_pkg;

	// Power-on sequencer states
	typedef enum logic [3:0] {
		st_start_dly = 4'd0,
		st_mmcm_rst  = 4'd1,
		st_wait_lock = 4'd2,
		st_adc_init  = 4'd3,
		st_align     = 4'd4,
		st_wait_bpi  = 4'd5,
		st_run       = 4'd6
	} por_state_t;

	// Asynchronous status levels from the board
	typedef struct packed {
		logic mmcm_lock;
		logic qpll_lock;
		logic al_done;
		logic bpi_seq_idle;
	} status_in_t;

	typedef struct packed {
		logic restart_all;
	} restart_t;

	typedef struct packed {
		logic adc_init_rst;
		logic al_start;
		logic mmcm_rst;
		logic sys_rst;
		logic run;
	} seq_ctrl_t;

	typedef logic [4:0] adc_attempt_t;

	localparam seq_ctrl_t SEQ_CTRL_RST = '{
		adc_init_rst: 1'b1,
		al_start:     1'b0,
		mmcm_rst:     1'b0,
		sys_rst:      1'b1,
		run:          1'b0
	};

endpackage

`default_nettype wire

// File: hw/status_sync.sv
`timescale 1ns/10ps
`default_nettype none

module status_sync #(
	parameter type PAYLOAD_T = logic
) (
	input  wire logic     STUP_CLK,
	input  wire logic     EOS,
	input  wire PAYLOAD_T d_i,
	output PAYLOAD_T      q_o
);

	// First stage may go metastable
	PAYLOAD_T meta_q;

	always_ff @(posedge STUP_CLK or negedge EOS) begin
		if (!EOS) begin
			meta_q <= '0;
			q_o    <= '0;
		end else begin
			meta_q <= d_i;
			q_o    <= meta_q;
		end
	end

endmodule

`default_nettype wire

// File: hw/startup_timer.sv
`timescale 1ns/10ps
`default_nettype none

module startup_timer #(
	parameter logic [19:0] STRT_DLY = 20'h7FFFF,
	parameter logic [6:0]  POR_TMO  = 7'd120
) (
	input  wire logic STUP_CLK,
	input  wire logic EOS,
	input  wire logic por_cnt_i,
	output logic      strt_dly_done_o,
	output logic      por_done_o
);

	logic [19:0] startup_cnt;
	logic [6:0]  por_tmr;

	assign strt_dly_done_o = (startup_cnt == STRT_DLY);
	assign por_done_o      = por_cnt_i && (por_tmr == POR_TMO);

	// Runs once after reset, then holds
	always_ff @(posedge STUP_CLK or negedge EOS) begin
		if (!EOS) begin
			startup_cnt <= '0;
		end else if (!strt_dly_done_o) begin
			startup_cnt <= startup_cnt + 20'd1;
		end
	end

	// MMCM reset hold timer, cleared whenever not enabled
	always_ff @(posedge STUP_CLK or negedge EOS) begin
		if (!EOS) begin
			por_tmr <= '0;
		end else if (!por_cnt_i) begin
			por_tmr <= '0;
		end else if (!por_done_o) begin
			por_tmr <= por_tmr + 7'd1;
		end
	end

	// Done only after a full hold interval with the enable up
	a_por_done_hold: assert property (
		@(posedge STUP_CLK) disable iff (!EOS)
		$rose(por_done_o) |-> por_cnt_i && $past(por_cnt_i, POR_TMO)
	) else $error("por_done rose without a full POR_TMO interval");

endmodule

`default_nettype wire

// File: hw/por_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module por_fsm (
	input  wire logic                    STUP_CLK,
	input  wire logic                    EOS,
	input  wire rst_seq_pkg::status_in_t status_i,
	input  wire rst_seq_pkg::restart_t   restart_i,
	input  wire logic                    strt_dly_done_i,
	input  wire logic                    por_done_i,
	input  wire logic                    adc_rdy_i,
	output logic                         por_cnt_o,
	output rst_seq_pkg::seq_ctrl_t       ctrl_o,
	output rst_seq_pkg::por_state_t      por_state_o
);

	import rst_seq_pkg::*;

	por_state_t state_q;
	por_state_t state_d;
	logic       align_q;
	seq_ctrl_t  ctrl_c;
	seq_ctrl_t  ctrl_r1;

	assign por_state_o = state_q;
	assign por_cnt_o   = (state_q == st_mmcm_rst);

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_start_dly: begin
				if (strt_dly_done_i) begin
					state_d = st_mmcm_rst;
				end
			end
			st_mmcm_rst: begin
				if (por_done_i) begin
					state_d = st_wait_lock;
				end
			end
			st_wait_lock: begin
				if (status_i.mmcm_lock && status_i.qpll_lock) begin
					state_d = st_adc_init;
				end
			end
			st_adc_init: begin
				if (adc_rdy_i) begin
					state_d = st_align;
				end
			end
			st_align: begin
				if (!status_i.mmcm_lock) begin
					state_d = st_mmcm_rst;
				end else if (status_i.al_done) begin
					state_d = st_wait_bpi;
				end
			end
			st_wait_bpi: begin
				if (!status_i.mmcm_lock) begin
					state_d = st_mmcm_rst;
				end else if (status_i.bpi_seq_idle) begin
					state_d = st_run;
				end
			end
			st_run: begin
				if (!status_i.mmcm_lock) begin
					state_d = st_mmcm_rst;
				end
			end
			default: state_d = st_start_dly;
		endcase

		// Restart wins once the startup delay is over
		if (restart_i.restart_all && state_q != st_start_dly) begin
			state_d = st_mmcm_rst;
		end
	end

	always_ff @(posedge STUP_CLK or negedge EOS) begin
		if (!EOS) begin
			state_q <= st_start_dly;
			align_q <= 1'b0;
		end else begin
			state_q <= state_d;
			align_q <= (state_q == st_align);
		end
	end

	// Moore decode of the control word
	always_comb begin
		ctrl_c = SEQ_CTRL_RST;
		case (state_q)
			st_mmcm_rst: ctrl_c.mmcm_rst = 1'b1;
			st_adc_init, st_wait_bpi: ctrl_c.adc_init_rst = 1'b0;
			st_align: begin
				ctrl_c.adc_init_rst = 1'b0;
				// Pulse on the first align cycle only
				ctrl_c.al_start     = !align_q;
			end
			st_run: begin
				ctrl_c.adc_init_rst = 1'b0;
				ctrl_c.sys_rst      = 1'b0;
				ctrl_c.run          = 1'b1;
			end
			default: ctrl_c = SEQ_CTRL_RST;
		endcase
	end

	// Two-stage output register
	always_ff @(posedge STUP_CLK or negedge EOS) begin
		if (!EOS) begin
			ctrl_r1 <= SEQ_CTRL_RST;
			ctrl_o  <= SEQ_CTRL_RST;
		end else begin
			ctrl_r1 <= ctrl_c;
			ctrl_o  <= ctrl_r1;
		end
	end

	a_run_excl: assert property (
		@(posedge STUP_CLK) disable iff (!EOS)
		!(ctrl_o.run && ctrl_o.sys_rst)
	) else $error("run and sys_rst high together");

	a_al_start_pulse: assert property (
		@(posedge STUP_CLK) disable iff (!EOS)
		ctrl_o.al_start |=> !ctrl_o.al_start
	) else $error("al_start longer than one cycle");

endmodule

`default_nettype wire

// File: hw/adc_init_seq.sv
`timescale 1ns/10ps
`default_nettype none

module adc_init_seq #(
	parameter logic [11:0] ADC_TMO     = 12'd1000,
	parameter logic [4:0]  ADC_MAX_TRY = 5'd16
) (
	input  wire logic                STUP_CLK,
	input  wire logic                EOS,
	input  wire logic                init_rst_i,
	input  wire logic                init_done_i,
	output logic                     adc_rdy_o,
	output logic                     adc_init_o,
	output logic                     adc_rst_o,
	output logic                     adc_fail_o,
	output rst_seq_pkg::adc_attempt_t try_o
);

	import rst_seq_pkg::*;

	logic         started_q;
	logic [11:0]  tmo_cnt;
	adc_attempt_t try_q;
	adc_attempt_t try_nxt;

	assign try_nxt = try_q + 5'd1;
	assign try_o   = try_q;

	always_ff @(posedge STUP_CLK or negedge EOS) begin
		if (!EOS) begin
			started_q  <= 1'b0;
			tmo_cnt    <= '0;
			try_q      <= '0;
			adc_rdy_o  <= 1'b0;
			adc_init_o <= 1'b0;
			adc_rst_o  <= 1'b0;
			adc_fail_o <= 1'b0;
		end else if (init_rst_i) begin
			started_q  <= 1'b0;
			tmo_cnt    <= '0;
			try_q      <= '0;
			adc_rdy_o  <= 1'b0;
			adc_init_o <= 1'b0;
			adc_rst_o  <= 1'b0;
			adc_fail_o <= 1'b0;
		end else begin
			adc_rst_o <= 1'b0;
			if (!started_q) begin
				// First attempt right after reset release
				started_q  <= 1'b1;
				adc_rst_o  <= 1'b1;
				adc_init_o <= 1'b1;
				tmo_cnt    <= '0;
			end else if (adc_init_o) begin
				if (init_done_i) begin
					adc_init_o <= 1'b0;
					adc_rdy_o  <= 1'b1;
				end else if (tmo_cnt == ADC_TMO - 12'd1) begin
					try_q <= try_nxt;
					if (try_nxt == ADC_MAX_TRY) begin
						adc_init_o <= 1'b0;
						adc_fail_o <= 1'b1;
					end else begin
						// Retry with a fresh ADC reset
						adc_rst_o <= 1'b1;
						tmo_cnt   <= '0;
					end
				end else begin
					tmo_cnt <= tmo_cnt + 12'd1;
				end
			end
		end
	end

	a_rdy_fail_excl: assert property (
		@(posedge STUP_CLK) disable iff (!EOS)
		!(adc_rdy_o && adc_fail_o)
	) else $error("adc ready and fail both high");

endmodule

`default_nettype wire

// File: hw/reset_manager.sv
`timescale 1ns/10ps
`default_nettype none

module reset_manager #(
	parameter logic [19:0] STRT_DLY    = 20'h7FFFF,
	parameter logic [6:0]  POR_TMO     = 7'd120,
	parameter logic [11:0] ADC_TMO     = 12'd1000,
	parameter logic [4:0]  ADC_MAX_TRY = 5'd16
) (
	input  wire logic                 STUP_CLK,
	input  wire logic                 EOS,
	input  wire logic                 jtag_sys_rst_i,
	input  wire logic                 csp_sys_rst_i,
	input  wire logic                 mmcm_lock_i,
	input  wire logic                 qpll_lock_i,
	input  wire logic                 al_done_i,
	input  wire logic                 bpi_seq_idle_i,
	input  wire logic                 adc_init_done_i,
	output logic                      mmcm_rst_o,
	output logic                      adc_init_rst_o,
	output logic                      al_start_o,
	output logic                      sys_rst_o,
	output logic                      run_o,
	output logic                      adc_init_o,
	output logic                      adc_rst_o,
	output logic                      adc_rdy_o,
	output logic                      adc_fail_o,
	output rst_seq_pkg::adc_attempt_t adc_try_o,
	output rst_seq_pkg::por_state_t   por_state_o
);

	import rst_seq_pkg::*;

	status_in_t status_raw;
	status_in_t status_s;
	restart_t   restart_raw;
	restart_t   restart_s;
	seq_ctrl_t  ctrl;
	logic       strt_dly_done;
	logic       por_done;
	logic       por_cnt;

	assign status_raw = '{
		mmcm_lock:    mmcm_lock_i,
		qpll_lock:    qpll_lock_i,
		al_done:      al_done_i,
		bpi_seq_idle: bpi_seq_idle_i
	};
	assign restart_raw.restart_all = jtag_sys_rst_i || csp_sys_rst_i;

	assign mmcm_rst_o     = ctrl.mmcm_rst;
	assign adc_init_rst_o = ctrl.adc_init_rst;
	assign al_start_o     = ctrl.al_start;
	assign sys_rst_o      = ctrl.sys_rst;
	assign run_o          = ctrl.run;

	status_sync #(.PAYLOAD_T(status_in_t)) status_sync_i (
		.STUP_CLK(STUP_CLK), .EOS(EOS), .d_i(status_raw), .q_o(status_s)
	);

	status_sync #(.PAYLOAD_T(restart_t)) restart_sync_i (
		.STUP_CLK(STUP_CLK), .EOS(EOS), .d_i(restart_raw), .q_o(restart_s)
	);

	startup_timer #(.STRT_DLY(STRT_DLY), .POR_TMO(POR_TMO)) startup_timer_i (
		.STUP_CLK(STUP_CLK), .EOS(EOS), .por_cnt_i(por_cnt),
		.strt_dly_done_o(strt_dly_done), .por_done_o(por_done)
	);

	por_fsm por_fsm_i (
		.STUP_CLK(STUP_CLK), .EOS(EOS), .status_i(status_s), .restart_i(restart_s),
		.strt_dly_done_i(strt_dly_done), .por_done_i(por_done), .adc_rdy_i(adc_rdy_o),
		.por_cnt_o(por_cnt), .ctrl_o(ctrl), .por_state_o(por_state_o)
	);

	adc_init_seq #(.ADC_TMO(ADC_TMO), .ADC_MAX_TRY(ADC_MAX_TRY)) adc_init_seq_i (
		.STUP_CLK(STUP_CLK), .EOS(EOS), .init_rst_i(ctrl.adc_init_rst),
		.init_done_i(adc_init_done_i), .adc_rdy_o(adc_rdy_o), .adc_init_o(adc_init_o),
		.adc_rst_o(adc_rst_o), .adc_fail_o(adc_fail_o), .try_o(adc_try_o)
	);

endmodule

`default_nettype wire

// File: bench/reset_manager_tb.sv
`timescale 1ns/10ps
`default_nettype none

module reset_manager_tb;

	import rst_seq_pkg::*;

	localparam int CLK_PERIOD      = 4;
	localparam int STRT_DLY        = 16;
	localparam int POR_TMO         = 8;
	localparam int ADC_TMO         = 12;
	localparam int ADC_MAX_TRY     = 4;
	localparam int NUM_ROWS        = 5;
	localparam int WAIT_LIMIT      = ADC_TMO * (ADC_MAX_TRY + 1) + 20;
	localparam int ROW_CYCLES      = 2 * (STRT_DLY + POR_TMO + ADC_TMO * ADC_MAX_TRY + 80);
	localparam int WATCHDOG_CYCLES = NUM_ROWS * ROW_CYCLES;

	// Lock delay comes from the LCG
	// A done_try of 0 means the ADC never answers
	typedef struct packed {
		logic [7:0]   lock_dly;
		logic [4:0]   done_try;
		logic [7:0]   restart_cyc;
		por_state_t   exp_state;
		logic         exp_run;
		logic         exp_fail;
		adc_attempt_t exp_try;
	} row_t;

	logic         STUP_CLK;
	logic         EOS;
	logic         jtag_sys_rst_i;
	logic         csp_sys_rst_i;
	logic         mmcm_lock_i;
	logic         qpll_lock_i;
	logic         al_done_i;
	logic         bpi_seq_idle_i;
	logic         adc_init_done_i;
	logic         mmcm_rst_o;
	logic         adc_init_rst_o;
	logic         al_start_o;
	logic         sys_rst_o;
	logic         run_o;
	logic         adc_init_o;
	logic         adc_rst_o;
	logic         adc_rdy_o;
	logic         adc_fail_o;
	adc_attempt_t adc_try_o;
	por_state_t   por_state_o;

	row_t         rows [NUM_ROWS];
	int unsigned  lcg_state;
	int           rst_pulses;
	int           al_pulses;
	int           wait_cnt;

	reset_manager #(
		.STRT_DLY(20'(STRT_DLY)),
		.POR_TMO(7'(POR_TMO)),
		.ADC_TMO(12'(ADC_TMO)),
		.ADC_MAX_TRY(5'(ADC_MAX_TRY))
	) reset_manager_i (.*);

	initial begin
		STUP_CLK = 1'b0;
		forever #(CLK_PERIOD / 2) STUP_CLK = ~STUP_CLK;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		give_up("Watchdog expired before all rows finished");
	end

	task automatic give_up(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check(input string name, input int got, input int exp);
		if (got != exp) begin
			give_up($sformatf("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, exp));
		end
	endtask

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Outputs sampled mid-cycle with pulses counted on the way
	task automatic tick();
		@(negedge STUP_CLK);
		if (adc_rst_o) begin
			rst_pulses++;
		end
		if (al_start_o) begin
			al_pulses++;
		end
	endtask

	task automatic tick_bounded(input string what);
		tick();
		wait_cnt++;
		if (wait_cnt > WAIT_LIMIT) begin
			give_up({"Timeout while waiting for ", what});
		end
	endtask

	task automatic clear_status();
		mmcm_lock_i     = 1'b0;
		qpll_lock_i     = 1'b0;
		al_done_i       = 1'b0;
		bpi_seq_idle_i  = 1'b0;
		adc_init_done_i = 1'b0;
	endtask

	task automatic apply_reset();
		EOS            = 1'b0;
		jtag_sys_rst_i = 1'b0;
		csp_sys_rst_i  = 1'b0;
		clear_status();
		repeat (5) @(negedge STUP_CLK);
		check("sys_rst_o", int'(sys_rst_o), 1);
		check("adc_init_rst_o", int'(adc_init_rst_o), 1);
		check("mmcm_rst_o", int'(mmcm_rst_o), 0);
		check("al_start_o", int'(al_start_o), 0);
		check("run_o", int'(run_o), 0);
		check("adc_init_o", int'(adc_init_o), 0);
		check("adc_rst_o", int'(adc_rst_o), 0);
		check("adc_fail_o", int'(adc_fail_o), 0);
		check("por_state_o", int'(por_state_o), int'(st_start_dly));
		EOS = 1'b1;
	endtask

	// From the MMCM reset step to run or to ADC failure
	task automatic run_sequence(input row_t row, input int min_start);
		clear_status();
		rst_pulses = 0;
		al_pulses  = 0;
		wait_cnt   = 0;
		while (!mmcm_rst_o) begin
			tick_bounded("mmcm_rst_o to rise");
		end
		if (min_start > 0) begin
			check("mmcm_rst_o start delay long enough", int'(wait_cnt >= min_start), 1);
		end
		wait_cnt = 0;
		while (mmcm_rst_o) begin
			tick_bounded("mmcm_rst_o to fall");
		end
		check("mmcm_rst_o hold long enough", int'(wait_cnt >= POR_TMO), 1);
		// One lock alone must not leave wait_lock
		if (row.lock_dly[0]) begin
			mmcm_lock_i = 1'b1;
		end else begin
			qpll_lock_i = 1'b1;
		end
		repeat (row.lock_dly) begin
			check("por_state_o", int'(por_state_o), int'(st_wait_lock));
			tick();
		end
		check("por_state_o", int'(por_state_o), int'(st_wait_lock));
		mmcm_lock_i = 1'b1;
		qpll_lock_i = 1'b1;

		wait_cnt = 0;
		while (!adc_rdy_o && !adc_fail_o) begin
			tick_bounded("adc_rdy_o or adc_fail_o");
			if (row.done_try != 5'd0 && rst_pulses == int'(row.done_try)) begin
				adc_init_done_i = 1'b1;
			end
		end
		if (row.done_try == 5'd0) begin
			check("adc_fail_o", int'(adc_fail_o), 1);
			check("adc_rdy_o", int'(adc_rdy_o), 0);
			check("adc_try_o", int'(adc_try_o), ADC_MAX_TRY);
			check("adc_rst_o pulse count", rst_pulses, ADC_MAX_TRY);
			repeat (20) begin
				tick();
				check("run_o", int'(run_o), 0);
				check("por_state_o", int'(por_state_o), int'(st_adc_init));
			end
		end else begin
			check("adc_fail_o", int'(adc_fail_o), 0);
			check("adc_rdy_o", int'(adc_rdy_o), 1);
			check("adc_try_o", int'(adc_try_o), int'(row.done_try) - 1);
			check("adc_rst_o pulse count", rst_pulses, int'(row.done_try));
			wait_cnt = 0;
			while (al_pulses == 0) begin
				tick_bounded("al_start_o");
			end
			al_done_i = 1'b1;
			wait_cnt = 0;
			while (por_state_o != st_wait_bpi) begin
				tick_bounded("st_wait_bpi");
			end
			bpi_seq_idle_i = 1'b1;
			wait_cnt = 0;
			while (!run_o) begin
				tick_bounded("run_o");
			end
			check("sys_rst_o", int'(sys_rst_o), 0);
			check("por_state_o", int'(por_state_o), int'(st_run));
			repeat (4) tick();
			check("al_start_o pulse count", al_pulses, 1);
		end
	endtask

	initial begin
		EOS             = 1'b0;
		jtag_sys_rst_i  = 1'b0;
		csp_sys_rst_i   = 1'b0;
		clear_status();
		lcg_state = 34;

		// lock_dly, done_try, restart_cyc, state, run, fail, try
		rows[0] = '{8'd0, 5'd1, 8'd0, st_run, 1'b1, 1'b0, 5'd0};
		rows[1] = '{8'd0, 5'd3, 8'd0, st_run, 1'b1, 1'b0, 5'd2};
		rows[2] = '{8'd0, 5'd0, 8'd0, st_adc_init, 1'b0, 1'b1, 5'd4};
		rows[3] = '{8'd0, 5'd2, 8'd5, st_run, 1'b1, 1'b0, 5'd1};
		rows[4] = '{8'd0, 5'd4, 8'd1, st_run, 1'b1, 1'b0, 5'd3};
		for (int r = 0; r < NUM_ROWS; r++) begin
			rows[r].lock_dly = 8'(1 + (lcg_next() >> 16) % 20);
		end

		for (int r = 0; r < NUM_ROWS; r++) begin
			apply_reset();
			run_sequence(rows[r], STRT_DLY);
			if (rows[r].restart_cyc != 8'd0) begin
				repeat (rows[r].restart_cyc) tick();
				if (r % 2 == 1) begin
					csp_sys_rst_i = 1'b1;
				end else begin
					jtag_sys_rst_i = 1'b1;
				end
				tick();
				csp_sys_rst_i  = 1'b0;
				jtag_sys_rst_i = 1'b0;
				wait_cnt = 0;
				while (por_state_o != st_mmcm_rst) begin
					tick_bounded("restart to reach st_mmcm_rst");
				end
				// Control word trails the state by two cycles
				tick();
				tick();
				check("sys_rst_o", int'(sys_rst_o), 1);
				check("run_o", int'(run_o), 0);
				check("adc_init_rst_o", int'(adc_init_rst_o), 1);
				run_sequence(rows[r], 0);
			end
			check("final por_state_o", int'(por_state_o), int'(rows[r].exp_state));
			check("final run_o", int'(run_o), int'(rows[r].exp_run));
			check("final adc_fail_o", int'(adc_fail_o), int'(rows[r].exp_fail));
			check("final adc_try_o", int'(adc_try_o), int'(rows[r].exp_try));
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
hw/rst_seq_pkg.sv
hw/status_sync.sv
hw/startup_timer.sv
hw/por_fsm.sv
hw/adc_init_seq.sv
hw/reset_manager.sv
bench/reset_manager_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f compile.f --top-module reset_manager_tb -o sim \
	&& ./obj_dir/sim > sim.log 2>&1 \
	|| { echo "Build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qF 'All tests passed!' sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
